// ==== verilog.f ====
+incdir+rtl
rtl/kbd_pkg.sv
rtl/video_pkg.sv
rtl/ps2_keyboard.sv
rtl/vga_timing.sv
rtl/text_display.sv
rtl/terminal_top.sv
tb/tb_terminal.sv

// ==== Makefile ====
TOP := tb_terminal

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

// ==== tb/tb_terminal.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "terminal_defines.svh"

module tb_terminal;

  import video_pkg::*;

  localparam int LINE     = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int FRAME    = LINE * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
  localparam int HALF_BIT = 20;  // PS/2 half bit in system clocks

  localparam int SEL_HSYNC = 0;
  localparam int SEL_VSYNC = 1;
  localparam int SEL_BLANK = 2;

  logic                    clk;
  logic                    rst_n;
  logic                    ps2_clk;
  logic                    ps2_data;
  logic                    font_we;
  logic [`FONT_ADDR_W-1:0] font_addr;
  logic [`CHAR_W-1:0]      font_data;
  logic                    vga_clk;
  logic                    hsync;
  logic                    vsync;
  logic                    blank_n;
  colour_t                 vga_r;
  colour_t                 vga_g;
  colour_t                 vga_b;

  int checks;
  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;
  bit aborted;

  logic [23:0] pix_buf [0:159];    // {r, g, b} of a scanned block
  logic [23:0] saved_buf [0:159];

  terminal_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ps2_clk   (ps2_clk),
    .ps2_data  (ps2_data),
    .font_we   (font_we),
    .font_addr (font_addr),
    .font_data (font_data),
    .vga_clk   (vga_clk),
    .hsync     (hsync),
    .vsync     (vsync),
    .blank_n   (blank_n),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b)
  );

  always #50 clk = ~clk;

  // ====================
  // Checks and reporting
  // ====================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_pixel(input int x, input int y, input logic [23:0] got,
                             input logic [23:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL vga_r/g/b at (%0d,%0d): got %h, expected %h", x, y, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    test_errors++;
    aborted = 1'b1;
    $display("ERROR: timed out waiting for %s", what);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // Glyph row r of code c with bit 0 leftmost
  function automatic logic [`CHAR_W-1:0] glyph_row(input int code, input int row);
    int bits;
    bits = (code ^ (row * 5)) & 'h1FF;
    return bits[`CHAR_W-1:0];
  endfunction

  function automatic logic sig_value(input int sel);
    case (sel)
      SEL_HSYNC: return hsync;
      SEL_VSYNC: return vsync;
      default:   return blank_n;
    endcase
  endfunction

  // ====================
  // Raster helpers
  // ====================
  // Returns on the falling clock edge where the new level is first seen
  task automatic wait_edge(input int sel, input logic level, input int limit,
                           input string what);
    int   n;
    logic prev;
    logic cur;
    n = 0;
    @(negedge clk);
    prev = sig_value(sel);
    @(negedge clk);
    cur = sig_value(sel);
    while (!(cur == level && prev != level) && n < limit && !aborted) begin
      prev = cur;
      @(negedge clk);
      cur = sig_value(sel);
      n++;
    end
    if (!aborted && !(cur == level && prev != level)) begin
      report_timeout(what);
    end
  endtask

  task automatic measure_level(input int sel, input logic level, input int limit,
                               input string what, output int cycles);
    cycles = 0;
    while (sig_value(sel) == level && cycles < limit && !aborted) begin
      @(negedge clk);
      cycles++;
    end
    if (!aborted && sig_value(sel) == level) begin
      report_timeout(what);
    end
  endtask

  // Sample a w by h pixel block with its top left corner at (x0, y0)
  task automatic scan_block(input int x0, input int y0, input int w, input int h);
    int pos;
    int target;
    int r;
    int c;
    wait_edge(SEL_VSYNC, 1'b1, 2 * FRAME, "vsync rising edge");
    wait_edge(SEL_BLANK, 1'b1, 40 * LINE, "first active pixel");
    pos = 0;  // Now at pixel (0,0)
    for (r = 0; r < h; r++) begin
      for (c = 0; c < w; c++) begin
        target = (y0 + r) * LINE + x0 + c;
        while (pos < target) begin
          @(negedge clk);
          pos++;
        end
        pix_buf[r * w + c] = {vga_r, vga_g, vga_b};
      end
    end
  endtask

  task automatic check_glyph(input int cx, input int cy, input int code);
    logic [`CHAR_W-1:0] bits;
    logic [23:0]        exp;
    int                 r;
    int                 c;
    scan_block(cx * `CHAR_W, cy * `CHAR_H, `CHAR_W, `CHAR_H);
    for (r = 0; r < `CHAR_H; r++) begin
      bits = glyph_row(code, r);
      for (c = 0; c < `CHAR_W; c++) begin
        exp = bits[c] ? 24'hFFFFFF : 24'h000000;
        check_pixel(cx * `CHAR_W + c, cy * `CHAR_H + r, pix_buf[r * `CHAR_W + c], exp);
      end
    end
  endtask

  // ====================
  // Stimulus helpers
  // ====================
  task automatic send_ps2(input logic [7:0] code, input bit parity_ok);
    logic [10:0] frame;
    logic        parity;
    int          i;
    parity = parity_ok ? ~^code : ^code;  // Odd parity when correct
    frame = {1'b1, parity, code, 1'b0};
    for (i = 0; i < 11; i++) begin
      @(posedge clk);
      ps2_data <= frame[i];
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    @(posedge clk);
    ps2_data <= 1'b1;
    repeat (4 * HALF_BIT) @(posedge clk);
  endtask

  task automatic load_font();
    int code;
    int row;
    for (code = 0; code < 128; code++) begin
      for (row = 0; row < `CHAR_H; row++) begin
        @(posedge clk);
        font_we   <= 1'b1;
        font_addr <= `FONT_ADDR_W'(code * `CHAR_H + row);
        font_data <= glyph_row(code, row);
      end
    end
    @(posedge clk);
    font_we <= 1'b0;
  endtask

  // ====================
  // Tests
  // ====================
  task automatic check_idle_outputs();
    check_value("hsync", 32'(hsync), 32'h1);
    check_value("vsync", 32'(vsync), 32'h1);
    check_value("blank_n", 32'(blank_n), 32'h0);
    check_value("vga_r", 32'(vga_r), 32'h0);
    check_value("vga_g", 32'(vga_g), 32'h0);
    check_value("vga_b", 32'(vga_b), 32'h0);
  endtask

  task automatic test_reset();
    int i;
    for (i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i == 2) begin
        rst_n <= 1'b1;  // Flops still see reset on this edge
      end
      @(negedge clk);
      check_idle_outputs();
    end
    @(negedge clk);
    check_idle_outputs();
    finish_test("reset");
  endtask

  task automatic test_timing();
    int low;
    int high;
    int gap;
    // Pixel clock follows the system clock in both phases
    @(posedge clk);
    #10;
    check_value("vga_clk", 32'(vga_clk), 32'h1);
    @(negedge clk);
    #10;
    check_value("vga_clk", 32'(vga_clk), 32'h0);
    wait_edge(SEL_HSYNC, 1'b0, 2 * LINE, "hsync falling edge");
    measure_level(SEL_HSYNC, 1'b0, 2 * LINE, "end of hsync pulse", low);
    measure_level(SEL_HSYNC, 1'b1, 2 * LINE, "next hsync pulse", high);
    check_value("hsync low cycles", low, `H_SYNC);
    check_value("hsync period", low + high, LINE);
    wait_edge(SEL_VSYNC, 1'b0, 2 * FRAME, "vsync falling edge");
    measure_level(SEL_VSYNC, 1'b0, FRAME, "end of vsync pulse", low);
    measure_level(SEL_VSYNC, 1'b1, 2 * FRAME, "next vsync pulse", high);
    check_value("vsync low cycles", low, `V_SYNC * LINE);
    check_value("vsync period", low + high, FRAME);
    wait_edge(SEL_BLANK, 1'b1, FRAME, "blank_n rising edge");
    measure_level(SEL_BLANK, 1'b1, 2 * LINE, "blank_n falling edge", high);
    check_value("blank_n high cycles", high, `H_ACTIVE);
    measure_level(SEL_HSYNC, 1'b1, LINE, "hsync after blanking", gap);
    check_value("blank_n to hsync cycles", gap, `H_FRONT);
    finish_test("timing");
  endtask

  task automatic test_typing();
    send_ps2(8'h1C, 1'b1);
    send_ps2(8'hF0, 1'b1);
    send_ps2(8'h1C, 1'b1);  // Release code is swallowed
    send_ps2(8'h32, 1'b1);
    check_glyph(0, 0, 'h61);
    check_glyph(1, 0, 'h62);
    finish_test("typing");
  endtask

  task automatic test_filtering();
    send_ps2(8'h05, 1'b1);  // Unmapped
    send_ps2(8'h2B, 1'b0);
    send_ps2(8'h21, 1'b1);
    check_glyph(2, 0, 'h63);
    finish_test("filtering");
  endtask

  task automatic test_enter();
    int i;
    int r;
    int c;
    scan_block(3 * `CHAR_W, 0, `CHAR_W, `CHAR_H);
    for (i = 0; i < `CHAR_W * `CHAR_H; i++) begin
      saved_buf[i] = pix_buf[i];
    end
    send_ps2(8'h5A, 1'b1);
    send_ps2(8'h45, 1'b1);
    check_glyph(0, 1, 'h30);
    scan_block(3 * `CHAR_W, 0, `CHAR_W, `CHAR_H);
    for (r = 0; r < `CHAR_H; r++) begin
      for (c = 0; c < `CHAR_W; c++) begin
        check_pixel(3 * `CHAR_W + c, r, pix_buf[r * `CHAR_W + c],
                    saved_buf[r * `CHAR_W + c]);
      end
    end
    finish_test("enter");
  endtask

  // Last 10 columns of the line lie outside the text grid
  task automatic test_margin();
    int w;
    int r;
    int c;
    w = `H_ACTIVE - `TEXT_COLS * `CHAR_W;
    scan_block(`TEXT_COLS * `CHAR_W, 0, w, `CHAR_H);
    for (r = 0; r < `CHAR_H; r++) begin
      for (c = 0; c < w; c++) begin
        check_pixel(`TEXT_COLS * `CHAR_W + c, r, pix_buf[r * w + c], 24'h000000);
      end
    end
    finish_test("margin");
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    ps2_clk      = 1'b1;
    ps2_data     = 1'b1;
    font_we      = 1'b0;
    font_addr    = '0;
    font_data    = '0;
    checks       = 0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;

    test_reset();
    load_font();
    if (!aborted) test_timing();
    if (!aborted) test_typing();
    if (!aborted) test_filtering();
    if (!aborted) test_enter();
    if (!aborted) test_margin();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/terminal_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "terminal_defines.svh"

module terminal_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ps2_clk,
  input  logic                    ps2_data,
  input  logic                    font_we,
  input  logic [`FONT_ADDR_W-1:0] font_addr,
  input  logic [`CHAR_W-1:0]      font_data,
  output logic                    vga_clk,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    blank_n,
  output video_pkg::colour_t      vga_r,
  output video_pkg::colour_t      vga_g,
  output video_pkg::colour_t      vga_b
);

  import kbd_pkg::*;
  import video_pkg::*;

  logic   char_valid;
  ascii_t char_code;

  hpos_t h_pos;
  vpos_t v_pos;
  logic  raster_active;
  logic  raster_hsync;
  logic  raster_vsync;

  assign vga_clk = clk;  // Pixel clock is the system clock

  // ====================
  // Keyboard front end
  // ====================
  ps2_keyboard kbd_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .char_valid (char_valid),
    .char_code  (char_code)
  );

  vga_timing timing_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .h_pos  (h_pos),
    .v_pos  (v_pos),
    .active (raster_active),
    .hsync  (raster_hsync),
    .vsync  (raster_vsync)
  );

  // ====================
  // Text display
  // ====================
  text_display disp_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .char_valid (char_valid),
    .char_code  (char_code),
    .font_we    (font_we),
    .font_addr  (font_addr),
    .font_data  (font_data),
    .h_pos      (h_pos),
    .v_pos      (v_pos),
    .active     (raster_active),
    .hsync      (raster_hsync),
    .vsync      (raster_vsync),
    .blank_n    (blank_n),
    .vga_hsync  (hsync),
    .vga_vsync  (vsync),
    .vga_r      (vga_r),
    .vga_g      (vga_g),
    .vga_b      (vga_b)
  );

endmodule

`default_nettype wire

// ==== rtl/text_display.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "terminal_defines.svh"

module text_display (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    char_valid,
  input  kbd_pkg::ascii_t         char_code,
  input  logic                    font_we,
  input  logic [`FONT_ADDR_W-1:0] font_addr,
  input  logic [`CHAR_W-1:0]      font_data,
  input  video_pkg::hpos_t        h_pos,
  input  video_pkg::vpos_t        v_pos,
  input  logic                    active,
  input  logic                    hsync,
  input  logic                    vsync,
  output logic                    blank_n,
  output logic                    vga_hsync,
  output logic                    vga_vsync,
  output video_pkg::colour_t      vga_r,
  output video_pkg::colour_t      vga_g,
  output video_pkg::colour_t      vga_b
);

  import kbd_pkg::*;
  import video_pkg::*;

  localparam int CELLS   = `TEXT_COLS * `TEXT_ROWS;  // 2100
  localparam int CELL_AW = $clog2(CELLS);
  localparam int COL_W   = $clog2(`TEXT_COLS);
  localparam int ROW_W   = $clog2(`TEXT_ROWS);
  localparam int GCOL_W  = $clog2(`CHAR_W);
  localparam int GROW_W  = $clog2(`CHAR_H);
  localparam int TEXT_W  = `TEXT_COLS * `CHAR_W;     // 630, rest of line blank
  localparam int TEXT_H  = `TEXT_ROWS * `CHAR_H;

  localparam logic [COL_W-1:0] LAST_COL = COL_W'(`TEXT_COLS - 1);
  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`TEXT_ROWS - 1);

  ascii_t            char_ram [CELLS];
  logic [`CHAR_W-1:0] font_ram [2**`FONT_ADDR_W];

  // ====================
  // Cursor and writes
  // ====================
  logic [COL_W-1:0]   cur_col;
  logic [ROW_W-1:0]   cur_row;
  logic [ROW_W-1:0]   next_row;
  logic [CELL_AW-1:0] wr_addr;

  assign next_row = (cur_row == LAST_ROW) ? '0 : cur_row + 1'b1;
  assign wr_addr  = CELL_AW'(cur_row * `TEXT_COLS + cur_col);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_col <= '0;
      cur_row <= '0;
    end else if (char_valid) begin
      if (char_code == CH_ENTER || cur_col == LAST_COL) begin
        cur_col <= '0;
        cur_row <= next_row;  // Wraps to the top after the last row
      end else begin
        cur_col <= cur_col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (char_valid && char_code != CH_ENTER) begin
      char_ram[wr_addr] <= char_code;
    end
    if (font_we) begin
      font_ram[font_addr] <= font_data;
    end
  end

  // ====================
  // Stage 1, cell lookup
  // ====================
  hpos_t              px_cell_col;
  hpos_t              px_glyph_col;
  vpos_t              px_cell_row;
  vpos_t              px_glyph_row;
  logic               in_text;
  logic [CELL_AW-1:0] rd_addr;

  assign px_cell_col  = h_pos / hpos_t'(`CHAR_W);
  assign px_glyph_col = h_pos % hpos_t'(`CHAR_W);
  assign px_cell_row  = v_pos / vpos_t'(`CHAR_H);
  assign px_glyph_row = v_pos % vpos_t'(`CHAR_H);
  assign in_text      = (h_pos < hpos_t'(TEXT_W)) && (v_pos < vpos_t'(TEXT_H));
  assign rd_addr      = in_text ? CELL_AW'(px_cell_row * `TEXT_COLS + px_cell_col) : '0;

  ascii_t            s1_char;
  logic [GCOL_W-1:0] s1_gcol;
  logic [GROW_W-1:0] s1_grow;
  logic              s1_show;
  logic              s1_active;
  logic              s1_hsync;
  logic              s1_vsync;

  always_ff @(posedge clk) begin
    s1_char <= char_ram[rd_addr];
    s1_gcol <= px_glyph_col[GCOL_W-1:0];
    s1_grow <= px_glyph_row[GROW_W-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_show   <= 1'b0;
      s1_active <= 1'b0;
      s1_hsync  <= 1'b1;
      s1_vsync  <= 1'b1;
    end else begin
      s1_show   <= active & in_text;
      s1_active <= active;
      s1_hsync  <= hsync;
      s1_vsync  <= vsync;
    end
  end

  // ====================
  // Stage 2, glyph pixel
  // ====================
  logic [`FONT_ADDR_W-1:0] glyph_addr;
  logic [`CHAR_W-1:0]      glyph_bits;
  logic                    pix_on;
  colour_t                 pix_colour;

  assign glyph_addr = {s1_char, s1_grow};  // Code times 16 plus row
  assign glyph_bits = font_ram[glyph_addr];
  assign pix_on     = s1_show & glyph_bits[s1_gcol];
  assign pix_colour = pix_on ? COLOUR_MAX : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      blank_n   <= 1'b0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_r     <= '0;
      vga_g     <= '0;
      vga_b     <= '0;
    end else begin
      blank_n   <= s1_active;
      vga_hsync <= s1_hsync;
      vga_vsync <= s1_vsync;
      vga_r     <= pix_colour;
      vga_g     <= pix_colour;
      vga_b     <= pix_colour;
    end
  end

  a_cursor_col: assert property (@(posedge clk) disable iff (!rst_n)
    cur_col <= LAST_COL)
    else $error("cursor column outside the text grid");

endmodule

`default_nettype wire

// ==== rtl/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "terminal_defines.svh"

module vga_timing (
  input  logic             clk,
  input  logic             rst_n,
  output video_pkg::hpos_t h_pos,
  output video_pkg::vpos_t v_pos,
  output logic             active,
  output logic             hsync,
  output logic             vsync
);

  import video_pkg::*;

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;  // 800
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;  // 525

  localparam hpos_t H_LAST   = hpos_t'(H_TOTAL - 1);
  localparam hpos_t H_ACT    = hpos_t'(`H_ACTIVE);
  localparam hpos_t HS_BEGIN = hpos_t'(`H_ACTIVE + `H_FRONT);
  localparam hpos_t HS_END   = hpos_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);

  localparam vpos_t V_LAST   = vpos_t'(V_TOTAL - 1);
  localparam vpos_t V_ACT    = vpos_t'(`V_ACTIVE);
  localparam vpos_t VS_BEGIN = vpos_t'(`V_ACTIVE + `V_FRONT);
  localparam vpos_t VS_END   = vpos_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

  hpos_t h_cnt;
  vpos_t v_cnt;

  // ====================
  // Counters
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_LAST) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // Registered decode, one cycle behind the counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_pos  <= '0;
      v_pos  <= '0;
      active <= 1'b0;
      hsync  <= 1'b1;
      vsync  <= 1'b1;
    end else begin
      h_pos  <= h_cnt;
      v_pos  <= v_cnt;
      active <= (h_cnt < H_ACT) && (v_cnt < V_ACT);
      hsync  <= !((h_cnt >= HS_BEGIN) && (h_cnt < HS_END));  // Active low
      vsync  <= !((v_cnt >= VS_BEGIN) && (v_cnt < VS_END));
    end
  end

  a_hpos_range: assert property (@(posedge clk) disable iff (!rst_n)
    h_pos <= H_LAST)
    else $error("h_pos beyond line length");

endmodule

`default_nettype wire

// ==== rtl/ps2_keyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            ps2_clk,
  input  logic            ps2_data,
  output logic            char_valid,
  output kbd_pkg::ascii_t char_code
);

  import kbd_pkg::*;

  // ====================
  // Line synchronizers
  // ====================
  logic ps2_clk_s1;
  logic ps2_clk_s2;
  logic ps2_clk_s3;
  logic ps2_data_s1;
  logic ps2_data_s2;
  logic ps2_fall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ps2_clk_s1  <= 1'b1;
      ps2_clk_s2  <= 1'b1;
      ps2_clk_s3  <= 1'b1;
      ps2_data_s1 <= 1'b1;
      ps2_data_s2 <= 1'b1;
    end else begin
      ps2_clk_s1  <= ps2_clk;
      ps2_clk_s2  <= ps2_clk_s1;
      ps2_clk_s3  <= ps2_clk_s2;
      ps2_data_s1 <= ps2_data;
      ps2_data_s2 <= ps2_data_s1;
    end
  end

  assign ps2_fall = ps2_clk_s3 & ~ps2_clk_s2;

  // ====================
  // Frame receiver
  // ====================
  logic [3:0] bit_cnt;
  logic [9:0] shift_q;     // Parity, data, start
  logic       frame_ok;
  logic       scan_valid;
  scan_code_t scan_code;

  // Start low, odd parity, stop high on the current bit
  assign frame_ok = ~shift_q[0] & (^shift_q[9:1]) & ps2_data_s2;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      scan_valid <= 1'b0;
    end else begin
      scan_valid <= 1'b0;
      if (ps2_fall) begin
        if (bit_cnt == 4'd10) begin
          bit_cnt    <= '0;
          scan_valid <= frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ps2_fall) begin
      if (bit_cnt == 4'd10) begin
        scan_code <= shift_q[8:1];
      end else begin
        shift_q <= {ps2_data_s2, shift_q[9:1]};  // LSB first
      end
    end
  end

  // ====================
  // Scan code to ASCII
  // ====================
  logic   break_seen;
  logic   map_hit;
  ascii_t map_char;

  always_comb begin
    map_hit  = 1'b1;
    map_char = '0;
    case (scan_code)
      8'h1C:    map_char = "a";
      8'h32:    map_char = "b";
      8'h21:    map_char = "c";
      8'h23:    map_char = "d";
      8'h24:    map_char = "e";
      8'h2B:    map_char = "f";
      8'h34:    map_char = "g";
      8'h33:    map_char = "h";
      8'h43:    map_char = "i";
      8'h3B:    map_char = "j";
      8'h42:    map_char = "k";
      8'h4B:    map_char = "l";
      8'h3A:    map_char = "m";
      8'h31:    map_char = "n";
      8'h44:    map_char = "o";
      8'h4D:    map_char = "p";
      8'h15:    map_char = "q";
      8'h2D:    map_char = "r";
      8'h1B:    map_char = "s";
      8'h2C:    map_char = "t";
      8'h3C:    map_char = "u";
      8'h2A:    map_char = "v";
      8'h1D:    map_char = "w";
      8'h22:    map_char = "x";
      8'h35:    map_char = "y";
      8'h1A:    map_char = "z";
      8'h45:    map_char = "0";
      8'h16:    map_char = "1";
      8'h1E:    map_char = "2";
      8'h26:    map_char = "3";
      8'h25:    map_char = "4";
      8'h2E:    map_char = "5";
      8'h36:    map_char = "6";
      8'h3D:    map_char = "7";
      8'h3E:    map_char = "8";
      8'h46:    map_char = "9";
      8'h29:    map_char = " ";
      SC_ENTER: map_char = CH_ENTER;
      default:  map_hit  = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      break_seen <= 1'b0;
      char_valid <= 1'b0;
    end else begin
      char_valid <= 1'b0;
      if (scan_valid) begin
        if (scan_code == SC_BREAK) begin
          break_seen <= 1'b1;
        end else if (break_seen) begin
          break_seen <= 1'b0;  // Code of the released key
        end else begin
          char_valid <= map_hit;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (scan_valid) begin
      char_code <= map_char;
    end
  end

  // Frames are hundreds of cycles apart, so events never touch
  a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    char_valid |=> !char_valid)
    else $error("char_valid high on consecutive cycles");

endmodule

`default_nettype wire

// ==== rtl/video_pkg.sv ====
`default_nettype none

package video_pkg;

  // Pixel coordinates, wide enough for the blanking ranges too
  typedef logic [9:0] hpos_t;
  typedef logic [9:0] vpos_t;

  // One colour channel
  typedef logic [7:0] colour_t;

  localparam colour_t COLOUR_MAX = 8'hFF;  // Full white

endpackage

`default_nettype wire

// ==== rtl/kbd_pkg.sv ====
`default_nettype none

package kbd_pkg;

  // ====================
  // Keyboard types
  // ====================

  // One byte from the PS/2 line, scan code set 2
  typedef logic [7:0] scan_code_t;

  // Character handed to the display
  typedef logic [7:0] ascii_t;

  // ====================
  // Scan codes
  // ====================

  // Prefix of a release sequence
  localparam scan_code_t SC_BREAK = 8'hF0;

  localparam scan_code_t SC_ENTER = 8'h5A;

  // Enter moves the cursor, never stored
  localparam ascii_t CH_ENTER = 8'h0D;

endpackage

`default_nettype wire

// ==== rtl/terminal_defines.svh ====
`ifndef TERMINAL_DEFINES_SVH
`define TERMINAL_DEFINES_SVH

// ====================
// Raster timing, 640x480
// ====================
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

// ====================
// Text grid and glyphs
// ====================
`define TEXT_COLS 70
`define TEXT_ROWS 30

`define CHAR_W 9  // Bit 0 is the leftmost pixel
`define CHAR_H 16

// ASCII code times 16 plus glyph row
`define FONT_ADDR_W 12

`endif
